// ==== src/bru_pkg.sv ====
// branch unit package
// shared widths, queue depth and the branch opcode encoding

package bru_pkg;

	// ------------------------------------------------------------
	// dispatch and queue sizing

	localparam int DISPATCH_WAYS = 2;
	localparam int BRU_IQ_ENTRIES = 4;
	localparam int LOG_BRU_IQ_ENTRIES = 2;

	// ------------------------------------------------------------
	// physical registers and writeback banks

	localparam int PR_COUNT = 32;
	localparam int LOG_PR_COUNT = 5;
	// bank is the low bit of a PR tag
	localparam int PRF_BANK_COUNT = 2;
	localparam int LOG_PRF_BANK_COUNT = 1;

	localparam int LOG_ROB_ENTRIES = 4;

	// data and PC width
	localparam int XLEN = 32;

	// ------------------------------------------------------------
	// branch ops
	// jumps in the low half, conditional branches with bit 3 set

	typedef enum logic [3:0] {
		BRU_JALR = 4'b0000,
		BRU_JAL  = 4'b0010,
		BRU_BEQ  = 4'b1000,
		BRU_BNE  = 4'b1001,
		BRU_BLT  = 4'b1100,
		BRU_BGE  = 4'b1101,
		BRU_BLTU = 4'b1110,
		BRU_BGEU = 4'b1111
	} bru_op_e;

endpackage

// ==== src/bru_iq.sv ====
// branch issue queue
// age-ordered entries that collapse on issue, so entry 0 is the oldest
// wakes sources from the banked writeback bus, issues the oldest ready op

`timescale 1ns/1ps

module bru_iq (
	input logic CLK,
	input logic nRST,

	// dispatch by way
	input logic [bru_pkg::DISPATCH_WAYS-1:0] dispatch_attempt,
	input logic [bru_pkg::DISPATCH_WAYS-1:0] dispatch_valid,
	input bru_pkg::bru_op_e [bru_pkg::DISPATCH_WAYS-1:0] dispatch_op,
	input logic [bru_pkg::DISPATCH_WAYS-1:0][bru_pkg::XLEN-1:0] dispatch_PC,
	input logic [bru_pkg::DISPATCH_WAYS-1:0][bru_pkg::XLEN-1:0] dispatch_pred_PC,
	input logic [bru_pkg::DISPATCH_WAYS-1:0][bru_pkg::XLEN-1:0] dispatch_imm,
	input logic [bru_pkg::DISPATCH_WAYS-1:0][bru_pkg::LOG_PR_COUNT-1:0] dispatch_A_PR,
	input logic [bru_pkg::DISPATCH_WAYS-1:0] dispatch_A_ready,
	input logic [bru_pkg::DISPATCH_WAYS-1:0][bru_pkg::LOG_PR_COUNT-1:0] dispatch_B_PR,
	input logic [bru_pkg::DISPATCH_WAYS-1:0] dispatch_B_ready,
	input logic [bru_pkg::DISPATCH_WAYS-1:0][bru_pkg::LOG_PR_COUNT-1:0] dispatch_dest_PR,
	input logic [bru_pkg::DISPATCH_WAYS-1:0][bru_pkg::LOG_ROB_ENTRIES-1:0] dispatch_ROB_index,
	output logic [bru_pkg::DISPATCH_WAYS-1:0] dispatch_ack,

	// writeback tags by bank
	input logic [bru_pkg::PRF_BANK_COUNT-1:0] WB_valid,
	input logic [bru_pkg::PRF_BANK_COUNT-1:0]
		[bru_pkg::LOG_PR_COUNT-bru_pkg::LOG_PRF_BANK_COUNT-1:0] WB_upper_PR,

	// issue to register read
	input logic read_ready,
	output logic issue_valid,
	output bru_pkg::bru_op_e issue_op,
	output logic [bru_pkg::XLEN-1:0] issue_PC,
	output logic [bru_pkg::XLEN-1:0] issue_pred_PC,
	output logic [bru_pkg::XLEN-1:0] issue_imm,
	output logic [bru_pkg::LOG_PR_COUNT-1:0] issue_A_PR,
	output logic [bru_pkg::LOG_PR_COUNT-1:0] issue_B_PR,
	output logic [bru_pkg::LOG_PR_COUNT-1:0] issue_dest_PR,
	output logic [bru_pkg::LOG_ROB_ENTRIES-1:0] issue_ROB_index
);

	// ------------------------------------------------------------
	// queue state, current and next

	logic [bru_pkg::BRU_IQ_ENTRIES-1:0] q_valid;
	logic [bru_pkg::BRU_IQ_ENTRIES-1:0] n_valid;
	bru_pkg::bru_op_e q_op [bru_pkg::BRU_IQ_ENTRIES];
	bru_pkg::bru_op_e n_op [bru_pkg::BRU_IQ_ENTRIES];
	logic [bru_pkg::XLEN-1:0] q_PC [bru_pkg::BRU_IQ_ENTRIES];
	logic [bru_pkg::XLEN-1:0] n_PC [bru_pkg::BRU_IQ_ENTRIES];
	logic [bru_pkg::XLEN-1:0] q_pred_PC [bru_pkg::BRU_IQ_ENTRIES];
	logic [bru_pkg::XLEN-1:0] n_pred_PC [bru_pkg::BRU_IQ_ENTRIES];
	logic [bru_pkg::XLEN-1:0] q_imm [bru_pkg::BRU_IQ_ENTRIES];
	logic [bru_pkg::XLEN-1:0] n_imm [bru_pkg::BRU_IQ_ENTRIES];
	logic [bru_pkg::LOG_PR_COUNT-1:0] q_A_PR [bru_pkg::BRU_IQ_ENTRIES];
	logic [bru_pkg::LOG_PR_COUNT-1:0] n_A_PR [bru_pkg::BRU_IQ_ENTRIES];
	logic [bru_pkg::LOG_PR_COUNT-1:0] q_B_PR [bru_pkg::BRU_IQ_ENTRIES];
	logic [bru_pkg::LOG_PR_COUNT-1:0] n_B_PR [bru_pkg::BRU_IQ_ENTRIES];
	logic [bru_pkg::LOG_PR_COUNT-1:0] q_dest_PR [bru_pkg::BRU_IQ_ENTRIES];
	logic [bru_pkg::LOG_PR_COUNT-1:0] n_dest_PR [bru_pkg::BRU_IQ_ENTRIES];
	logic [bru_pkg::LOG_ROB_ENTRIES-1:0] q_ROB_index [bru_pkg::BRU_IQ_ENTRIES];
	logic [bru_pkg::LOG_ROB_ENTRIES-1:0] n_ROB_index [bru_pkg::BRU_IQ_ENTRIES];
	logic [bru_pkg::BRU_IQ_ENTRIES-1:0] q_A_ready;
	logic [bru_pkg::BRU_IQ_ENTRIES-1:0] n_A_ready;
	logic [bru_pkg::BRU_IQ_ENTRIES-1:0] q_B_ready;
	logic [bru_pkg::BRU_IQ_ENTRIES-1:0] n_B_ready;

	// select
	logic [bru_pkg::BRU_IQ_ENTRIES-1:0] eligible;
	logic [bru_pkg::LOG_BRU_IQ_ENTRIES-1:0] sel_idx;
	logic sel_found;
	logic issue_fire;

	// tag hit on the bank picked by the tag's low bits
	function automatic logic wb_match(
		input logic [bru_pkg::LOG_PR_COUNT-1:0] pr,
		input logic [bru_pkg::PRF_BANK_COUNT-1:0] valid,
		input logic [bru_pkg::PRF_BANK_COUNT-1:0]
			[bru_pkg::LOG_PR_COUNT-bru_pkg::LOG_PRF_BANK_COUNT-1:0] upper
	);
		logic [bru_pkg::LOG_PRF_BANK_COUNT-1:0] bank;
		bank = pr[bru_pkg::LOG_PRF_BANK_COUNT-1:0];
		return valid[bank]
			&& (upper[bank] == pr[bru_pkg::LOG_PR_COUNT-1:bru_pkg::LOG_PRF_BANK_COUNT]);
	endfunction

	// ------------------------------------------------------------
	// oldest-ready select

	always_comb begin
		sel_idx = '0;
		// scan down so the lowest ready index wins
		for (int i = bru_pkg::BRU_IQ_ENTRIES - 1; i >= 0; i--) begin
			eligible[i] = q_valid[i]
				&& (q_op[i] == bru_pkg::BRU_JAL || q_A_ready[i])
				&& (q_op[i] inside {bru_pkg::BRU_JAL, bru_pkg::BRU_JALR} || q_B_ready[i]);
			if (eligible[i]) begin
				sel_idx = i[bru_pkg::LOG_BRU_IQ_ENTRIES-1:0];
			end
		end
	end

	assign sel_found = |eligible;
	assign issue_fire = sel_found && read_ready;

	// ------------------------------------------------------------
	// wakeup, collapse and dispatch

	always_comb begin
		int unsigned src;
		int unsigned slot;

		n_valid = q_valid;
		n_op = q_op;
		n_PC = q_PC;
		n_pred_PC = q_pred_PC;
		n_imm = q_imm;
		n_A_PR = q_A_PR;
		n_B_PR = q_B_PR;
		n_dest_PR = q_dest_PR;
		n_ROB_index = q_ROB_index;
		n_A_ready = q_A_ready;
		n_B_ready = q_B_ready;
		dispatch_ack = '0;

		// entries above the issued one shift down a slot
		for (int i = 0; i < bru_pkg::BRU_IQ_ENTRIES; i++) begin
			src = i;
			if (issue_fire && i >= sel_idx) begin
				src = i + 1;
			end
			if (src < bru_pkg::BRU_IQ_ENTRIES) begin
				n_valid[i] = q_valid[src];
				n_op[i] = q_op[src];
				n_PC[i] = q_PC[src];
				n_pred_PC[i] = q_pred_PC[src];
				n_imm[i] = q_imm[src];
				n_A_PR[i] = q_A_PR[src];
				n_B_PR[i] = q_B_PR[src];
				n_dest_PR[i] = q_dest_PR[src];
				n_ROB_index[i] = q_ROB_index[src];
				n_A_ready[i] = q_A_ready[src] || wb_match(q_A_PR[src], WB_valid, WB_upper_PR);
				n_B_ready[i] = q_B_ready[src] || wb_match(q_B_PR[src], WB_valid, WB_upper_PR);
			end else begin
				n_valid[i] = 1'b0;
			end
		end

		// survivors are packed low, so the count is the first free slot
		slot = 0;
		for (int i = 0; i < bru_pkg::BRU_IQ_ENTRIES; i++) begin
			slot = slot + n_valid[i];
		end

		// way 0 takes the first free slot, way 1 the next
		for (int w = 0; w < bru_pkg::DISPATCH_WAYS; w++) begin
			dispatch_ack[w] = dispatch_attempt[w] && (slot < bru_pkg::BRU_IQ_ENTRIES);
			if (dispatch_ack[w] && dispatch_valid[w]) begin
				n_valid[slot] = 1'b1;
				n_op[slot] = dispatch_op[w];
				n_PC[slot] = dispatch_PC[w];
				n_pred_PC[slot] = dispatch_pred_PC[w];
				n_imm[slot] = dispatch_imm[w];
				n_A_PR[slot] = dispatch_A_PR[w];
				n_B_PR[slot] = dispatch_B_PR[w];
				n_dest_PR[slot] = dispatch_dest_PR[w];
				n_ROB_index[slot] = dispatch_ROB_index[w];
				// catch a writeback landing in the dispatch cycle
				n_A_ready[slot] = dispatch_A_ready[w]
					|| wb_match(dispatch_A_PR[w], WB_valid, WB_upper_PR);
				n_B_ready[slot] = dispatch_B_ready[w]
					|| wb_match(dispatch_B_PR[w], WB_valid, WB_upper_PR);
				slot = slot + 1;
			end
		end
	end

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			q_valid <= '0;
		end else begin
			q_valid <= n_valid;
		end
	end

	always_ff @(posedge CLK) begin
		q_op <= n_op;
		q_PC <= n_PC;
		q_pred_PC <= n_pred_PC;
		q_imm <= n_imm;
		q_A_PR <= n_A_PR;
		q_B_PR <= n_B_PR;
		q_dest_PR <= n_dest_PR;
		q_ROB_index <= n_ROB_index;
		q_A_ready <= n_A_ready;
		q_B_ready <= n_B_ready;
	end

	// ------------------------------------------------------------
	// issue register, held while read stage is stalled

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			issue_valid <= 1'b0;
		end else if (read_ready) begin
			issue_valid <= sel_found;
		end
	end

	always_ff @(posedge CLK) begin
		if (issue_fire) begin
			issue_op <= q_op[sel_idx];
			issue_PC <= q_PC[sel_idx];
			issue_pred_PC <= q_pred_PC[sel_idx];
			issue_imm <= q_imm[sel_idx];
			issue_A_PR <= q_A_PR[sel_idx];
			issue_B_PR <= q_B_PR[sel_idx];
			issue_dest_PR <= q_dest_PR[sel_idx];
			issue_ROB_index <= q_ROB_index[sel_idx];
		end
	end

endmodule

// ==== src/bru_reg_read.sv ====
// branch register read stage
// physical register file filled by the writeback bus, operand read with
// same-cycle bypass into a one-entry output register

`timescale 1ns/1ps

module bru_reg_read (
	input logic CLK,
	input logic nRST,

	// issue from queue
	input logic issue_valid,
	input bru_pkg::bru_op_e issue_op,
	input logic [bru_pkg::XLEN-1:0] issue_PC,
	input logic [bru_pkg::XLEN-1:0] issue_pred_PC,
	input logic [bru_pkg::XLEN-1:0] issue_imm,
	input logic [bru_pkg::LOG_PR_COUNT-1:0] issue_A_PR,
	input logic [bru_pkg::LOG_PR_COUNT-1:0] issue_B_PR,
	input logic [bru_pkg::LOG_PR_COUNT-1:0] issue_dest_PR,
	input logic [bru_pkg::LOG_ROB_ENTRIES-1:0] issue_ROB_index,
	output logic read_ready,

	// writeback bus by bank
	input logic [bru_pkg::PRF_BANK_COUNT-1:0] WB_valid,
	input logic [bru_pkg::PRF_BANK_COUNT-1:0]
		[bru_pkg::LOG_PR_COUNT-bru_pkg::LOG_PRF_BANK_COUNT-1:0] WB_upper_PR,
	input logic [bru_pkg::PRF_BANK_COUNT-1:0][bru_pkg::XLEN-1:0] WB_data,

	// operands to resolve
	input logic exec_ready,
	output logic exec_valid,
	output bru_pkg::bru_op_e exec_op,
	output logic [bru_pkg::XLEN-1:0] exec_PC,
	output logic [bru_pkg::XLEN-1:0] exec_pred_PC,
	output logic [bru_pkg::XLEN-1:0] exec_imm,
	output logic [bru_pkg::XLEN-1:0] exec_A,
	output logic [bru_pkg::XLEN-1:0] exec_B,
	output logic [bru_pkg::LOG_PR_COUNT-1:0] exec_dest_PR,
	output logic [bru_pkg::LOG_ROB_ENTRIES-1:0] exec_ROB_index
);

	logic [bru_pkg::XLEN-1:0] prf [bru_pkg::PR_COUNT];
	logic [bru_pkg::LOG_PR_COUNT-1:0] wb_PR [bru_pkg::PRF_BANK_COUNT];
	logic [bru_pkg::LOG_PR_COUNT-1:0] src_PR [2];
	logic [bru_pkg::XLEN-1:0] src_data [2];

	// full tag is the upper bits with the bank number below
	always_comb begin
		for (int b = 0; b < bru_pkg::PRF_BANK_COUNT; b++) begin
			wb_PR[b] = {WB_upper_PR[b], b[bru_pkg::LOG_PRF_BANK_COUNT-1:0]};
		end
	end

	// PR 0 is never written and stays zero
	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			for (int i = 0; i < bru_pkg::PR_COUNT; i++) begin
				prf[i] <= '0;
			end
		end else begin
			for (int b = 0; b < bru_pkg::PRF_BANK_COUNT; b++) begin
				if (WB_valid[b] && wb_PR[b] != '0) begin
					prf[wb_PR[b]] <= WB_data[b];
				end
			end
		end
	end

	// ------------------------------------------------------------
	// operand read, A then B

	assign src_PR[0] = issue_A_PR;
	assign src_PR[1] = issue_B_PR;

	always_comb begin
		for (int k = 0; k < 2; k++) begin
			src_data[k] = prf[src_PR[k]];
			// bypass a writeback in the same cycle
			for (int b = 0; b < bru_pkg::PRF_BANK_COUNT; b++) begin
				if (WB_valid[b] && wb_PR[b] == src_PR[k] && src_PR[k] != '0) begin
					src_data[k] = WB_data[b];
				end
			end
		end
	end

	// ------------------------------------------------------------
	// output register

	assign read_ready = !exec_valid || exec_ready;

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			exec_valid <= 1'b0;
		end else if (read_ready) begin
			exec_valid <= issue_valid;
		end
	end

	always_ff @(posedge CLK) begin
		if (read_ready && issue_valid) begin
			exec_op <= issue_op;
			exec_PC <= issue_PC;
			exec_pred_PC <= issue_pred_PC;
			exec_imm <= issue_imm;
			exec_A <= src_data[0];
			exec_B <= src_data[1];
			exec_dest_PR <= issue_dest_PR;
			exec_ROB_index <= issue_ROB_index;
		end
	end

endmodule

// ==== src/bru_resolve.sv ====
// branch resolve stage
// evaluates the condition, computes the real next PC against the predicted
// one and produces the JAL/JALR link value, all into an output register

`timescale 1ns/1ps

module bru_resolve (
	input logic CLK,
	input logic nRST,

	// operands from read stage
	input logic exec_valid,
	input bru_pkg::bru_op_e exec_op,
	input logic [bru_pkg::XLEN-1:0] exec_PC,
	input logic [bru_pkg::XLEN-1:0] exec_pred_PC,
	input logic [bru_pkg::XLEN-1:0] exec_imm,
	input logic [bru_pkg::XLEN-1:0] exec_A,
	input logic [bru_pkg::XLEN-1:0] exec_B,
	input logic [bru_pkg::LOG_PR_COUNT-1:0] exec_dest_PR,
	input logic [bru_pkg::LOG_ROB_ENTRIES-1:0] exec_ROB_index,
	output logic exec_ready,

	// result
	input logic resolve_ready,
	output logic resolve_valid,
	output logic [bru_pkg::LOG_ROB_ENTRIES-1:0] resolve_ROB_index,
	output logic resolve_mispredict,
	output logic [bru_pkg::XLEN-1:0] resolve_target_PC,
	output logic resolve_link_valid,
	output logic [bru_pkg::LOG_PR_COUNT-1:0] resolve_link_PR,
	output logic [bru_pkg::XLEN-1:0] resolve_link_data
);

	logic taken;
	logic is_jump;
	logic [bru_pkg::XLEN-1:0] target_base;
	logic [bru_pkg::XLEN-1:0] target_sum;
	logic [bru_pkg::XLEN-1:0] seq_PC;
	logic [bru_pkg::XLEN-1:0] target_PC;

	// ------------------------------------------------------------
	// condition

	always_comb begin
		case (exec_op)
			bru_pkg::BRU_JAL,
			bru_pkg::BRU_JALR: taken = 1'b1;
			bru_pkg::BRU_BEQ:  taken = exec_A == exec_B;
			bru_pkg::BRU_BNE:  taken = exec_A != exec_B;
			bru_pkg::BRU_BLT:  taken = $signed(exec_A) < $signed(exec_B);
			bru_pkg::BRU_BGE:  taken = $signed(exec_A) >= $signed(exec_B);
			bru_pkg::BRU_BLTU: taken = exec_A < exec_B;
			bru_pkg::BRU_BGEU: taken = exec_A >= exec_B;
			default:           taken = 1'b0;
		endcase
	end

	// ------------------------------------------------------------
	// target

	assign is_jump = exec_op inside {bru_pkg::BRU_JAL, bru_pkg::BRU_JALR};

	// JALR is register relative, everything else PC relative
	assign target_base = (exec_op == bru_pkg::BRU_JALR) ? exec_A : exec_PC;
	assign target_sum = target_base + exec_imm;
	assign seq_PC = exec_PC + 'd4;

	always_comb begin
		if (!taken) begin
			target_PC = seq_PC;
		end else if (exec_op == bru_pkg::BRU_JALR) begin
			target_PC = {target_sum[bru_pkg::XLEN-1:1], 1'b0};
		end else begin
			target_PC = target_sum;
		end
	end

	// ------------------------------------------------------------
	// output register, frozen while the result is not taken

	assign exec_ready = !resolve_valid || resolve_ready;

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			resolve_valid <= 1'b0;
		end else if (exec_ready) begin
			resolve_valid <= exec_valid;
		end
	end

	always_ff @(posedge CLK) begin
		if (exec_ready && exec_valid) begin
			resolve_ROB_index <= exec_ROB_index;
			resolve_mispredict <= target_PC != exec_pred_PC;
			resolve_target_PC <= target_PC;
			resolve_link_valid <= is_jump;
			resolve_link_PR <= exec_dest_PR;
			resolve_link_data <= seq_PC;
		end
	end

endmodule

// ==== src/bru_pipe.sv ====
// branch unit top
// issue queue, register read and resolve stages in a chain

`timescale 1ns/1ps

module bru_pipe (
	input logic CLK,
	input logic nRST,

	// dispatch by way
	input logic [bru_pkg::DISPATCH_WAYS-1:0] dispatch_attempt,
	input logic [bru_pkg::DISPATCH_WAYS-1:0] dispatch_valid,
	input bru_pkg::bru_op_e [bru_pkg::DISPATCH_WAYS-1:0] dispatch_op,
	input logic [bru_pkg::DISPATCH_WAYS-1:0][bru_pkg::XLEN-1:0] dispatch_PC,
	input logic [bru_pkg::DISPATCH_WAYS-1:0][bru_pkg::XLEN-1:0] dispatch_pred_PC,
	input logic [bru_pkg::DISPATCH_WAYS-1:0][bru_pkg::XLEN-1:0] dispatch_imm,
	input logic [bru_pkg::DISPATCH_WAYS-1:0][bru_pkg::LOG_PR_COUNT-1:0] dispatch_A_PR,
	input logic [bru_pkg::DISPATCH_WAYS-1:0] dispatch_A_ready,
	input logic [bru_pkg::DISPATCH_WAYS-1:0][bru_pkg::LOG_PR_COUNT-1:0] dispatch_B_PR,
	input logic [bru_pkg::DISPATCH_WAYS-1:0] dispatch_B_ready,
	input logic [bru_pkg::DISPATCH_WAYS-1:0][bru_pkg::LOG_PR_COUNT-1:0] dispatch_dest_PR,
	input logic [bru_pkg::DISPATCH_WAYS-1:0][bru_pkg::LOG_ROB_ENTRIES-1:0] dispatch_ROB_index,
	output logic [bru_pkg::DISPATCH_WAYS-1:0] dispatch_ack,

	// writeback bus by bank
	input logic [bru_pkg::PRF_BANK_COUNT-1:0] WB_valid,
	input logic [bru_pkg::PRF_BANK_COUNT-1:0]
		[bru_pkg::LOG_PR_COUNT-bru_pkg::LOG_PRF_BANK_COUNT-1:0] WB_upper_PR,
	input logic [bru_pkg::PRF_BANK_COUNT-1:0][bru_pkg::XLEN-1:0] WB_data,

	// result
	input logic resolve_ready,
	output logic resolve_valid,
	output logic [bru_pkg::LOG_ROB_ENTRIES-1:0] resolve_ROB_index,
	output logic resolve_mispredict,
	output logic [bru_pkg::XLEN-1:0] resolve_target_PC,
	output logic resolve_link_valid,
	output logic [bru_pkg::LOG_PR_COUNT-1:0] resolve_link_PR,
	output logic [bru_pkg::XLEN-1:0] resolve_link_data
);

	// ------------------------------------------------------------
	// queue to read stage

	logic read_ready;
	logic issue_valid;
	bru_pkg::bru_op_e issue_op;
	logic [bru_pkg::XLEN-1:0] issue_PC;
	logic [bru_pkg::XLEN-1:0] issue_pred_PC;
	logic [bru_pkg::XLEN-1:0] issue_imm;
	logic [bru_pkg::LOG_PR_COUNT-1:0] issue_A_PR;
	logic [bru_pkg::LOG_PR_COUNT-1:0] issue_B_PR;
	logic [bru_pkg::LOG_PR_COUNT-1:0] issue_dest_PR;
	logic [bru_pkg::LOG_ROB_ENTRIES-1:0] issue_ROB_index;

	// read stage to resolve
	logic exec_ready;
	logic exec_valid;
	bru_pkg::bru_op_e exec_op;
	logic [bru_pkg::XLEN-1:0] exec_PC;
	logic [bru_pkg::XLEN-1:0] exec_pred_PC;
	logic [bru_pkg::XLEN-1:0] exec_imm;
	logic [bru_pkg::XLEN-1:0] exec_A;
	logic [bru_pkg::XLEN-1:0] exec_B;
	logic [bru_pkg::LOG_PR_COUNT-1:0] exec_dest_PR;
	logic [bru_pkg::LOG_ROB_ENTRIES-1:0] exec_ROB_index;

	bru_iq i_iq (.*);

	bru_reg_read i_reg_read (.*);

	bru_resolve i_resolve (.*);

endmodule

// ==== tb/tb_bru_vectors.svh ====
// branch unit test table
// one row per dispatched op, or a writeback row with no dispatch
// columns are wb tag, wb data, control, op, PC, pred PC, imm,
//          A tag, A ready, B tag, B ready, dest tag, expected taken

`ifndef TB_BRU_VECTORS_SVH
`define TB_BRU_VECTORS_SVH

task automatic load_table();
	// register setup over both banks
	wb(2, 32'd5, 0);
	wb(3, 32'd5, 0);
	wb(4, 32'hffff_ffff, 0);
	wb(5, 32'd1, 0);
	wb(6, 32'h8000_0000, 0);
	wb(7, 32'h7fff_ffff, 0);
	wb(8, 32'h0000_1003, 0);

	// ------------------------------------------------------------
	// conditional branches taken and not taken
	op(C_PAIR, bru_pkg::BRU_BEQ, 'h100, 'h140, 'h40, 2, 1, 3, 1, 20, 1);
	op(0, bru_pkg::BRU_BEQ, 'h104, 'h144, 'h40, 2, 1, 5, 1, 21, 0);
	op(C_PAIR, bru_pkg::BRU_BNE, 'h108, 'h148, 'h40, 2, 1, 5, 1, 22, 1);
	op(0, bru_pkg::BRU_BNE, 'h10c, 'h110, 'h40, 2, 1, 3, 1, 23, 0);
	// -1 < 1 signed but not unsigned
	op(C_PAIR, bru_pkg::BRU_BLT, 'h110, 'h150, 'h40, 4, 1, 5, 1, 24, 1);
	op(0, bru_pkg::BRU_BLT, 'h114, 'h118, 'hffff_fff8, 5, 1, 4, 1, 25, 0);
	op(C_PAIR, bru_pkg::BRU_BLT, 'h118, 'h110, 'hffff_fff8, 6, 1, 7, 1, 26, 1);
	op(0, bru_pkg::BRU_BGE, 'h11c, 'h15c, 'h40, 7, 1, 6, 1, 27, 1);
	op(C_PAIR, bru_pkg::BRU_BGE, 'h120, 'h160, 'h40, 4, 1, 5, 1, 28, 0);
	op(0, bru_pkg::BRU_BLTU, 'h124, 'h164, 'h40, 5, 1, 4, 1, 29, 1);
	op(C_PAIR, bru_pkg::BRU_BLTU, 'h128, 'h12c, 'h40, 4, 1, 5, 1, 30, 0);
	op(0, bru_pkg::BRU_BGEU, 'h12c, 'h16c, 'h40, 4, 1, 5, 1, 31, 1);
	op(C_PAIR, bru_pkg::BRU_BGEU, 'h130, 'h170, 'h40, 6, 1, 7, 1, 20, 1);
	op(C_DRAIN, bru_pkg::BRU_BGEU, 'h134, 'h138, 'h40, 5, 1, 4, 1, 21, 0);

	// jumps with unused sources never ready
	op(C_LAT | C_DRAIN, bru_pkg::BRU_JAL, 'h200, 'h280, 'h80, 0, 0, 0, 0, 9, 1);
	op(0, bru_pkg::BRU_JALR, 'h300, 'h1006, 'h4, 8, 1, 17, 0, 10, 1);
	op(C_DRAIN, bru_pkg::BRU_JALR, 'h304, 'h1000, 'h4, 8, 1, 0, 0, 11, 1);

	// ------------------------------------------------------------
	// wakeup where the younger ready op goes first
	op(0, bru_pkg::BRU_BEQ, 'h400, 'h440, 'h40, 14, 0, 2, 1, 12, 1);
	op(0, bru_pkg::BRU_BNE, 'h404, 'h408, 'h40, 2, 1, 3, 1, 13, 0);
	// same upper tag on the other bank wakes nothing
	wb(15, 32'd0, 0);
	wb(14, 32'd5, C_DRAIN);
	// writeback in the dispatch cycle
	row(15, 32'd7, C_DRAIN, bru_pkg::BRU_BLTU, 'h500, 'h504, 'h40, 15, 0, 5, 1, 14, 0);
	// writeback while the op sits in the read stage
	op(0, bru_pkg::BRU_BGEU, 'h600, 'h640, 'h40, 16, 1, 5, 1, 15, 1);
	wb(0, 32'd0, 0);
	wb(16, 32'd3, C_DRAIN);

	// ------------------------------------------------------------
	// result held low until the queue is full
	op(C_PAIR | C_LOW, bru_pkg::BRU_BEQ, 'h700, 'h740, 'h40, 2, 1, 3, 1, 20, 1);
	op(0, bru_pkg::BRU_BNE, 'h704, 'h708, 'h40, 2, 1, 3, 1, 21, 0);
	op(C_PAIR | C_LOW, bru_pkg::BRU_BLT, 'h708, 'h70c, 'h40, 4, 1, 5, 1, 22, 1);
	op(0, bru_pkg::BRU_BLTU, 'h70c, 'h710, 'h40, 4, 1, 5, 1, 23, 0);
	op(C_PAIR | C_LOW, bru_pkg::BRU_JAL, 'h710, 'h750, 'h40, 0, 0, 0, 0, 24, 1);
	op(0, bru_pkg::BRU_BGE, 'h714, 'h754, 'h40, 7, 1, 6, 1, 25, 1);
	op(C_PAIR | C_LOW, bru_pkg::BRU_BGEU, 'h718, 'h71c, 'h40, 5, 1, 4, 1, 26, 0);
	op(0, bru_pkg::BRU_JALR, 'h71c, 'h1006, 'h4, 8, 1, 0, 0, 27, 1);
	op(C_PAIR | C_LOW, bru_pkg::BRU_BEQ, 'h720, 'h724, 'h40, 2, 1, 5, 1, 28, 0);
	op(C_DRAIN, bru_pkg::BRU_BNE, 'h724, 'h764, 'h40, 6, 1, 7, 1, 29, 1);

	// random result stalls
	op(C_PAIR | C_RAND, bru_pkg::BRU_BLT, 'h800, 'h840, 'h40, 6, 1, 7, 1, 20, 1);
	op(0, bru_pkg::BRU_BGE, 'h804, 'h808, 'h40, 6, 1, 7, 1, 21, 0);
	op(C_PAIR | C_RAND, bru_pkg::BRU_JAL, 'h808, 'h900, 'h100, 0, 0, 0, 0, 22, 1);
	op(0, bru_pkg::BRU_BLTU, 'h80c, 'h84c, 'h40, 5, 1, 6, 1, 23, 1);
	op(C_RAND, bru_pkg::BRU_BGEU, 'h810, 'h814, 'h40, 3, 1, 2, 1, 24, 1);
	op(C_PAIR | C_RAND, bru_pkg::BRU_BEQ, 'h814, 'h818, 'h40, 4, 1, 4, 1, 25, 1);
	op(0, bru_pkg::BRU_JALR, 'h818, 'h1007, 'h4, 8, 1, 0, 0, 26, 1);
	op(C_PAIR | C_RAND, bru_pkg::BRU_BNE, 'h81c, 'h820, 'h40, 3, 1, 2, 1, 27, 0);
	op(C_DRAIN, bru_pkg::BRU_BLT, 'h820, 'h824, 'h40, 7, 1, 6, 1, 28, 0);
endtask

`endif

// ==== tb/tb_bru_pipe.sv ====
// branch unit testbench
// table-driven dispatch and writeback stimulus, scoreboard result checker

`timescale 1ns/1ps

module tb_bru_pipe;

	localparam int MAX_ROWS = 64;
	localparam int CYCLES_PER_ROW = 40;
	localparam int CLK_PERIOD = 20;
	localparam int FULL_DEPTH = 7;
	// row control bits
	localparam int C_NODISP = 1;
	localparam int C_PAIR = 2;
	localparam int C_DRAIN = 4;
	localparam int C_LAT = 8;
	localparam int C_LOW = 16;
	localparam int C_RAND = 32;

	logic CLK;
	logic nRST;
	logic [1:0] dispatch_attempt;
	logic [1:0] dispatch_valid;
	bru_pkg::bru_op_e [1:0] dispatch_op;
	logic [1:0][31:0] dispatch_PC;
	logic [1:0][31:0] dispatch_pred_PC;
	logic [1:0][31:0] dispatch_imm;
	logic [1:0][4:0] dispatch_A_PR;
	logic [1:0] dispatch_A_ready;
	logic [1:0][4:0] dispatch_B_PR;
	logic [1:0] dispatch_B_ready;
	logic [1:0][4:0] dispatch_dest_PR;
	logic [1:0][3:0] dispatch_ROB_index;
	logic [1:0] dispatch_ack;
	logic [1:0] WB_valid;
	logic [1:0][3:0] WB_upper_PR;
	logic [1:0][31:0] WB_data;
	logic resolve_ready;
	logic resolve_valid;
	logic [3:0] resolve_ROB_index;
	logic resolve_mispredict;
	logic [31:0] resolve_target_PC;
	logic resolve_link_valid;
	logic [4:0] resolve_link_PR;
	logic [31:0] resolve_link_data;

	// stimulus table
	int n_rows = 0;
	int t_wb_tag [MAX_ROWS];
	logic [31:0] t_wb_data [MAX_ROWS];
	int t_ctl [MAX_ROWS];
	bru_pkg::bru_op_e t_op [MAX_ROWS];
	logic [31:0] t_pc [MAX_ROWS];
	logic [31:0] t_pred [MAX_ROWS];
	logic [31:0] t_imm [MAX_ROWS];
	logic [4:0] t_a [MAX_ROWS];
	logic t_ar [MAX_ROWS];
	logic [4:0] t_b [MAX_ROWS];
	logic t_br [MAX_ROWS];
	logic [4:0] t_dest [MAX_ROWS];
	logic t_taken [MAX_ROWS];

	integer seed = 32'h9158;
	logic [31:0] shadow [32];
	int sb_row [$];
	logic [3:0] sb_rob [$];
	int sb_ack [$];
	int cyc = 0;
	bit held = 0;
	bit overtaken_seen = 0;
	bit blocked_seen = 0;
	logic [3:0] held_rob;
	logic held_mis;
	logic [31:0] held_target;
	logic held_link_valid;
	logic [4:0] held_link_PR;
	logic [31:0] held_link;

	bru_pipe i_dut (.*);

	always #(CLK_PERIOD / 2) CLK = ~CLK;

	task automatic row(input int wb_tag, input logic [31:0] wb_data, input int ctl,
		input bru_pkg::bru_op_e opc, input logic [31:0] pc, input logic [31:0] pred,
		input logic [31:0] imm, input logic [4:0] a, input logic ar,
		input logic [4:0] b, input logic br, input logic [4:0] dest, input logic taken);
		t_wb_tag[n_rows] = wb_tag;
		t_wb_data[n_rows] = wb_data;
		t_ctl[n_rows] = ctl;
		t_op[n_rows] = opc;
		t_pc[n_rows] = pc;
		t_pred[n_rows] = pred;
		t_imm[n_rows] = imm;
		t_a[n_rows] = a;
		t_ar[n_rows] = ar;
		t_b[n_rows] = b;
		t_br[n_rows] = br;
		t_dest[n_rows] = dest;
		t_taken[n_rows] = taken;
		n_rows++;
	endtask

	task automatic op(input int ctl, input bru_pkg::bru_op_e opc, input logic [31:0] pc,
		input logic [31:0] pred, input logic [31:0] imm, input logic [4:0] a, input logic ar,
		input logic [4:0] b, input logic br, input logic [4:0] dest, input logic taken);
		row(0, 32'd0, ctl, opc, pc, pred, imm, a, ar, b, br, dest, taken);
	endtask

	task automatic wb(input int tag, input logic [31:0] data, input int ctl);
		row(tag, data, ctl | C_NODISP, bru_pkg::BRU_JAL, 0, 0, 0, 0, 1, 0, 1, 0, 1);
	endtask

	`include "tb_bru_vectors.svh"

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			stop_run($sformatf("Fail %s expected %h actual %h", name, exp, act));
		end
	endtask

	function automatic bit is_jump(input bru_pkg::bru_op_e opc);
		return opc == bru_pkg::BRU_JAL || opc == bru_pkg::BRU_JALR;
	endfunction

	// an op waits on a source it really uses
	function automatic bit waits_on_wb(input int r);
		bit need_a;
		bit need_b;
		need_a = t_op[r] != bru_pkg::BRU_JAL;
		need_b = !is_jump(t_op[r]);
		return (need_a && !t_ar[r]) || (need_b && !t_br[r]);
	endfunction

	function automatic logic [31:0] next_pc(input int r);
		logic [31:0] sum;
		sum = shadow[t_a[r]] + t_imm[r];
		if (!t_taken[r]) begin
			return t_pc[r] + 32'd4;
		end
		if (t_op[r] == bru_pkg::BRU_JALR) begin
			return sum & ~32'd1;
		end
		return t_pc[r] + t_imm[r];
	endfunction

	// ------------------------------------------------------------
	// result checker

	always @(posedge CLK) begin : result_check
		int idx;
		int r;
		logic [31:0] target;
		if (nRST) begin
			cyc = cyc + 1;
			if (held) begin
				if (!resolve_valid) begin
					stop_run("a held result was dropped before it was taken");
				end
				check("hold_rob", held_rob, resolve_ROB_index);
				check("hold_mispredict", held_mis, resolve_mispredict);
				check("hold_target", held_target, resolve_target_PC);
				check("hold_link_valid", held_link_valid, resolve_link_valid);
				check("hold_link_PR", held_link_PR, resolve_link_PR);
				check("hold_link_data", held_link, resolve_link_data);
			end
			held = resolve_valid && !resolve_ready;
			held_rob = resolve_ROB_index;
			held_mis = resolve_mispredict;
			held_target = resolve_target_PC;
			held_link_valid = resolve_link_valid;
			held_link_PR = resolve_link_PR;
			held_link = resolve_link_data;
			if (resolve_valid && resolve_ready) begin
				idx = -1;
				for (int i = 0; i < sb_rob.size(); i++) begin
					if (idx < 0 && sb_rob[i] == resolve_ROB_index) begin
						idx = i;
					end
				end
				if (idx < 0) begin
					stop_run("a result arrived that matches no dispatched op");
				end
				for (int j = 0; j < idx; j++) begin
					if (!waits_on_wb(sb_row[j])) begin
						stop_run("a result overtook an older op with ready operands");
					end
					overtaken_seen = 1;
				end
				r = sb_row[idx];
				target = next_pc(r);
				check($sformatf("row%0d_target", r), target, resolve_target_PC);
				check($sformatf("row%0d_mispredict", r), target != t_pred[r],
					resolve_mispredict);
				check($sformatf("row%0d_link_valid", r), is_jump(t_op[r]), resolve_link_valid);
				if (is_jump(t_op[r])) begin
					check($sformatf("row%0d_link_PR", r), t_dest[r], resolve_link_PR);
					check($sformatf("row%0d_link_data", r), t_pc[r] + 32'd4, resolve_link_data);
				end
				if (t_ctl[r] & C_LAT) begin
					check($sformatf("row%0d_latency", r), 3, cyc - sb_ack[idx] - 1);
				end
				sb_row.delete(idx);
				sb_rob.delete(idx);
				sb_ack.delete(idx);
			end
		end
	end

	// ------------------------------------------------------------
	// stimulus

	task automatic drive_way(input int w, input int r, input logic [3:0] rob);
		dispatch_attempt[w] = 1'b1;
		dispatch_valid[w] = 1'b1;
		dispatch_op[w] = t_op[r];
		dispatch_PC[w] = t_pc[r];
		dispatch_pred_PC[w] = t_pred[r];
		dispatch_imm[w] = t_imm[r];
		dispatch_A_PR[w] = t_a[r];
		dispatch_A_ready[w] = t_ar[r];
		dispatch_B_PR[w] = t_b[r];
		dispatch_B_ready[w] = t_br[r];
		dispatch_dest_PR[w] = t_dest[r];
		dispatch_ROB_index[w] = rob;
	endtask

	task automatic idle_inputs();
		dispatch_attempt = '0;
		dispatch_valid = '0;
		WB_valid = '0;
	endtask

	task automatic apply_row(inout int i, inout logic [3:0] rob_next);
		int r [2];
		logic [3:0] rob [2];
		bit pend [2];
		bit first;
		bit released;
		bit drain;
		int waited;
		int ctl;
		r[0] = i;
		r[1] = i + 1;
		ctl = t_ctl[i];
		pend[0] = !(ctl & C_NODISP);
		pend[1] = (ctl & C_PAIR) != 0;
		drain = (ctl & C_DRAIN) || (pend[1] && (t_ctl[i + 1] & C_DRAIN));
		rob[0] = rob_next;
		rob[1] = rob_next + 4'd1;
		rob_next = rob_next + 4'd2;
		first = 1;
		released = 0;
		waited = 0;
		while (first || pend[0] || pend[1]) begin
			@(negedge CLK);
			idle_inputs();
			if (first && t_wb_tag[i] != 0) begin
				WB_valid[t_wb_tag[i] % 2] = 1'b1;
				WB_upper_PR[t_wb_tag[i] % 2] = t_wb_tag[i] / 2;
				WB_data[t_wb_tag[i] % 2] = t_wb_data[i];
				shadow[t_wb_tag[i]] = t_wb_data[i];
			end
			first = 0;
			if (ctl & C_RAND) begin
				resolve_ready = $random(seed) & 1;
			end else begin
				resolve_ready = !((ctl & C_LOW) && !released);
			end
			for (int w = 0; w < 2; w++) begin
				if (pend[w]) begin
					drive_way(w, r[w], rob[w]);
				end
			end
			#5;
			for (int w = 0; w < 2; w++) begin
				if (pend[w] && dispatch_ack[w]) begin
					sb_row.push_back(r[w]);
					sb_rob.push_back(rob[w]);
					sb_ack.push_back(cyc + 1);
					pend[w] = 0;
				end
			end
			waited++;
			// full pipe with result held must refuse further dispatch
			if ((ctl & C_LOW) && !released && waited >= 8 && (pend[0] || pend[1])) begin
				check("full_depth", FULL_DEPTH, sb_row.size());
				released = 1;
				blocked_seen = 1;
			end
		end
		i = i + (((ctl & C_PAIR) != 0) ? 2 : 1);
		while (drain && sb_row.size() != 0) begin
			@(negedge CLK);
			idle_inputs();
			resolve_ready = (ctl & C_RAND) ? ($random(seed) & 1) : 1'b1;
		end
	endtask

	initial begin : main
		int i;
		logic [3:0] rob_next;
		CLK = 0;
		nRST = 0;
		resolve_ready = 1;
		WB_upper_PR = '0;
		WB_data = '0;
		dispatch_PC = '0;
		dispatch_pred_PC = '0;
		dispatch_imm = '0;
		dispatch_A_PR = '0;
		dispatch_A_ready = '0;
		dispatch_B_PR = '0;
		dispatch_B_ready = '0;
		dispatch_dest_PR = '0;
		dispatch_ROB_index = '0;
		dispatch_op[0] = bru_pkg::BRU_JAL;
		dispatch_op[1] = bru_pkg::BRU_JAL;
		idle_inputs();
		for (int k = 0; k < 32; k++) begin
			shadow[k] = '0;
		end
		load_table();
		repeat (8) @(posedge CLK);
		@(negedge CLK);
		nRST = 1;
		// quiet after reset
		repeat (3) begin
			@(negedge CLK);
			#5;
			check("idle_ack", 0, dispatch_ack);
			check("idle_resolve_valid", 0, resolve_valid);
		end
		// attempt without valid enters nothing
		@(negedge CLK);
		dispatch_attempt = 2'b11;
		@(negedge CLK);
		idle_inputs();
		repeat (6) @(negedge CLK);
		i = 0;
		rob_next = '0;
		while (i < n_rows) begin
			apply_row(i, rob_next);
		end
		// any late extra result is taken and caught
		resolve_ready = 1'b1;
		repeat (4) @(negedge CLK);
		if (!blocked_seen) begin
			stop_run("dispatch was never refused while the result was held");
		end else if (!overtaken_seen) begin
			stop_run("no ready op ever passed an op waiting on writeback");
		end else begin
			$display("Simulation finished: PASS");
			$finish;
		end
	end

	initial begin : watchdog
		@(posedge nRST);
		#((n_rows * CYCLES_PER_ROW + 20) * CLK_PERIOD);
		stop_run("watchdog expired before the test table was finished");
	end

endmodule

// ==== src.f ====
src/bru_pkg.sv
src/bru_iq.sv
src/bru_reg_read.sv
src/bru_resolve.sv
src/bru_pipe.sv
+incdir+tb
tb/tb_bru_pipe.sv

// ==== Bender.yml ====
package:
  name: bru_pipe

sources:
  - files:
      - src/bru_pkg.sv
      - src/bru_iq.sv
      - src/bru_reg_read.sv
      - src/bru_resolve.sv
      - src/bru_pipe.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_bru_pipe.sv
